//--- design/cdp_rdma_reg_macros.svh
`ifndef CDP_RDMA_REG_MACROS_SVH
`define CDP_RDMA_REG_MACROS_SVH

// byte offsets within the 4KB register space
`define CDP_RDMA_S_STATUS           12'h000
`define CDP_RDMA_S_POINTER          12'h004
`define CDP_RDMA_D_OP_ENABLE        12'h008 // first dual reg
`define CDP_RDMA_D_CUBE_WIDTH       12'h00c
`define CDP_RDMA_D_CUBE_HEIGHT      12'h010
`define CDP_RDMA_D_CUBE_CHANNEL     12'h014
`define CDP_RDMA_D_SRC_BASE_LOW     12'h018
`define CDP_RDMA_D_SRC_BASE_HIGH    12'h01c
`define CDP_RDMA_D_SRC_LINE_STRIDE  12'h020
`define CDP_RDMA_D_SRC_SURF_STRIDE  12'h024
`define CDP_RDMA_D_SRC_DMA_CFG      12'h028 // ram type in bit 0
`define CDP_RDMA_D_DATA_FORMAT      12'h034 // input data in 1:0

// field widths
`define CDP_RDMA_DATA_W   32
`define CDP_RDMA_CUBE_W   13
`define CDP_RDMA_FMT_W    2
`define CDP_RDMA_OFFS_W   12
`define CDP_RDMA_WADDR_W  22

// enable pipe depths
`define CDP_RDMA_OP_EN_DLY  3
`define CDP_RDMA_SLCG_DLY   3

// per-group status codes
`define CDP_RDMA_ST_IDLE     2'd0
`define CDP_RDMA_ST_RUNNING  2'd1
`define CDP_RDMA_ST_PENDING  2'd2

`endif

//--- design/cdp_rdma_reg_pkg.sv
`include "cdp_rdma_reg_macros.svh"

package cdp_rdma_reg_pkg;

  // csb request, addr sits at bit 0
  typedef struct packed {
    logic [1:0]                   level;
    logic [3:0]                   wrbe;
    logic                         srcpriv;
    logic                         nposted;
    logic                         write;
    logic [`CDP_RDMA_DATA_W-1:0]  wdat;
    logic [`CDP_RDMA_WADDR_W-1:0] addr;  // word address
  } csb_req_t;

  // csb response, is_write on top
  typedef struct packed {
    logic                        is_write;
    logic                        error;
    logic [`CDP_RDMA_DATA_W-1:0] data;
  } csb_resp_t;

  // internal register access
  typedef struct packed {
    logic                        rd_en;
    logic                        wr_en;
    logic [`CDP_RDMA_DATA_W-1:0] wr_data;
    logic [`CDP_RDMA_OFFS_W-1:0] offset;  // byte offset
  } reg_acc_t;

  // one group's worth of data path config
  typedef struct packed {
    logic                        ram_type;
    logic [`CDP_RDMA_DATA_W-1:0] surf_stride;
    logic [`CDP_RDMA_DATA_W-1:0] line_stride;
    logic [`CDP_RDMA_DATA_W-1:0] base_high;
    logic [`CDP_RDMA_DATA_W-1:0] base_low;
    logic [`CDP_RDMA_FMT_W-1:0]  input_data;
    logic [`CDP_RDMA_CUBE_W-1:0] channel;
    logic [`CDP_RDMA_CUBE_W-1:0] height;
    logic [`CDP_RDMA_CUBE_W-1:0] width;
  } rdma_cfg_t;

endpackage

//--- design/cdp_rdma_csb_port.sv
`timescale 1ns/10ps
`include "cdp_rdma_reg_macros.svh"

module cdp_rdma_csb_port
  import cdp_rdma_reg_pkg::*;
(
  input  logic                        nvdla_core_clk,
  input  logic                        nvdla_core_rstn,
  input  csb_req_t                    csb_req,
  input  logic                        csb_req_pvld,
  output logic                        csb_req_prdy,
  input  logic [`CDP_RDMA_DATA_W-1:0] rd_data,
  output reg_acc_t                    reg_acc,
  output csb_resp_t                   csb_resp,
  output logic                        csb_resp_valid
);

  logic     req_pvld;
  csb_req_t req_pd;
  logic     wr_np;  // non-posted write this cycle

  assign csb_req_prdy = 1'b1;  // never stalls

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      req_pvld <= 1'b0;
    end else begin
      req_pvld <= csb_req_pvld;
    end
  end

  // payload only moves on a valid beat
  always_ff @(posedge nvdla_core_clk) begin
    if (csb_req_pvld) begin
      req_pd <= csb_req;
    end
  end

  // word address -> byte offset
  always_comb begin
    reg_acc.offset  = {req_pd.addr[`CDP_RDMA_OFFS_W-3:0], 2'b00};
    reg_acc.wr_data = req_pd.wdat;
    reg_acc.wr_en   = req_pvld & req_pd.write;
    reg_acc.rd_en   = req_pvld & ~req_pd.write;
  end

  assign wr_np = reg_acc.wr_en & req_pd.nposted;

  //////////////////////////////////////////////////////////////////////
  // response packet
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk) begin
    if (reg_acc.rd_en) begin
      csb_resp <= '{is_write: 1'b0, error: 1'b0, data: rd_data};  // read data
    end else if (wr_np) begin
      csb_resp <= '{is_write: 1'b1, error: 1'b0, data: '0};  // write ack, no data
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      csb_resp_valid <= 1'b0;
    end else begin
      csb_resp_valid <= reg_acc.rd_en | wr_np;  // posted writes stay silent
    end
  end

endmodule

//--- design/cdp_rdma_reg_ctrl.sv
`timescale 1ns/10ps
`include "cdp_rdma_reg_macros.svh"

module cdp_rdma_reg_ctrl
  import cdp_rdma_reg_pkg::*;
(
  input  logic                        nvdla_core_clk,
  input  logic                        nvdla_core_rstn,
  input  reg_acc_t                    reg_acc,
  output logic [`CDP_RDMA_DATA_W-1:0] rd_data,
  output reg_acc_t                    grp0_acc,
  output reg_acc_t                    grp1_acc,
  input  logic [`CDP_RDMA_DATA_W-1:0] grp0_rd_data,
  input  logic [`CDP_RDMA_DATA_W-1:0] grp1_rd_data,
  input  rdma_cfg_t                   grp0_cfg,
  input  rdma_cfg_t                   grp1_cfg,
  input  logic                        dp2reg_done,
  output rdma_cfg_t                   reg2dp_cfg,
  output logic                        reg2dp_op_en,
  output logic                        slcg_op_en
);

  logic                           producer;   // group sw programs
  logic                           consumer;   // group dp runs
  logic [1:0]                     op_en;
  logic [1:0][1:0]                status;
  logic                           sel_s;
  logic                           sel_op;
  logic                           op_en_sel;
  logic [`CDP_RDMA_DATA_W-1:0]    s_rd_data;
  logic [`CDP_RDMA_DATA_W-1:0]    d_rd_data;
  logic [`CDP_RDMA_OP_EN_DLY-1:0] op_en_dly;
  logic [`CDP_RDMA_SLCG_DLY-1:0]  slcg_dly;

  assign sel_s  = reg_acc.offset < `CDP_RDMA_D_OP_ENABLE;   // single range below dual
  assign sel_op = reg_acc.offset == `CDP_RDMA_D_OP_ENABLE;

  //////////////////////////////////////////////////////////////////////
  // pointers
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      producer <= 1'b0;
      consumer <= 1'b0;
    end else begin
      if (reg_acc.wr_en && reg_acc.offset == `CDP_RDMA_S_POINTER) begin
        producer <= reg_acc.wr_data[0];
      end
      if (dp2reg_done) begin
        consumer <= ~consumer;  // hop to the other group
      end
    end
  end

  // per-group op_en and status
  for (genvar g = 0; g < 2; g++) begin : g_grp
    assign status[g] = !op_en[g]          ? `CDP_RDMA_ST_IDLE    :
                       (consumer == 1'(g)) ? `CDP_RDMA_ST_RUNNING :
                                            `CDP_RDMA_ST_PENDING;

    always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
      if (!nvdla_core_rstn) begin
        op_en[g] <= 1'b0;
      end else if (!op_en[g] && reg_acc.wr_en && sel_op && producer == 1'(g)) begin
        op_en[g] <= reg_acc.wr_data[0];  // arm
      end else if (dp2reg_done && consumer == 1'(g)) begin
        op_en[g] <= 1'b0;  // layer finished
      end
    end
  end

  // dual accesses go to producer group, locked while armed
  always_comb begin
    grp0_acc       = reg_acc;
    grp1_acc       = reg_acc;
    grp0_acc.wr_en = reg_acc.wr_en & ~sel_s & ~producer & ~op_en[0];
    grp1_acc.wr_en = reg_acc.wr_en & ~sel_s & producer & ~op_en[1];
    grp0_acc.rd_en = reg_acc.rd_en & ~sel_s & ~producer;
    grp1_acc.rd_en = reg_acc.rd_en & ~sel_s & producer;
  end

  //////////////////////////////////////////////////////////////////////
  // read mux
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    s_rd_data = '0;
    case (reg_acc.offset)
      `CDP_RDMA_S_STATUS: begin
        s_rd_data[1:0]   = status[0];
        s_rd_data[17:16] = status[1];
      end
      `CDP_RDMA_S_POINTER: begin
        s_rd_data[0]  = producer;
        s_rd_data[16] = consumer;  // read only
      end
      default: ;
    endcase
  end

  assign d_rd_data = sel_op   ? {{(`CDP_RDMA_DATA_W-1){1'b0}}, op_en[producer]} :
                     producer ? grp1_rd_data : grp0_rd_data;
  assign rd_data   = sel_s ? s_rd_data : d_rd_data;

  // consumer group feeds the dp
  assign reg2dp_cfg = consumer ? grp1_cfg : grp0_cfg;
  assign op_en_sel  = op_en[consumer];

  // enable delay lines, done flushes the op_en pipe
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_en_dly <= '0;
      slcg_dly  <= '0;
    end else begin
      op_en_dly <= dp2reg_done ? '0 : {op_en_dly[`CDP_RDMA_OP_EN_DLY-2:0], op_en_sel};
      slcg_dly  <= {slcg_dly[`CDP_RDMA_SLCG_DLY-2:0], op_en_sel};
    end
  end

  assign reg2dp_op_en = op_en_dly[`CDP_RDMA_OP_EN_DLY-1];
  assign slcg_op_en   = slcg_dly[`CDP_RDMA_SLCG_DLY-1];

endmodule

//--- design/cdp_rdma_cfg_group.sv
`timescale 1ns/10ps
`include "cdp_rdma_reg_macros.svh"

module cdp_rdma_cfg_group
  import cdp_rdma_reg_pkg::*;
(
  input  logic                        nvdla_core_clk,
  input  logic                        nvdla_core_rstn,
  input  reg_acc_t                    acc,
  output logic [`CDP_RDMA_DATA_W-1:0] rd_data,
  output rdma_cfg_t                   cfg
);

  //////////////////////////////////////////////////////////////////////
  // field writes, wr_en already gated by op_en upstream
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cfg <= '0;
    end else if (acc.wr_en) begin
      case (acc.offset)
        `CDP_RDMA_D_CUBE_WIDTH: begin
          cfg.width <= acc.wr_data[`CDP_RDMA_CUBE_W-1:0];
        end
        `CDP_RDMA_D_CUBE_HEIGHT: begin
          cfg.height <= acc.wr_data[`CDP_RDMA_CUBE_W-1:0];
        end
        `CDP_RDMA_D_CUBE_CHANNEL: begin
          cfg.channel <= acc.wr_data[`CDP_RDMA_CUBE_W-1:0];
        end
        `CDP_RDMA_D_SRC_BASE_LOW: begin
          cfg.base_low <= acc.wr_data;
        end
        `CDP_RDMA_D_SRC_BASE_HIGH: begin
          cfg.base_high <= acc.wr_data;
        end
        `CDP_RDMA_D_SRC_LINE_STRIDE: begin
          cfg.line_stride <= acc.wr_data;
        end
        `CDP_RDMA_D_SRC_SURF_STRIDE: begin
          cfg.surf_stride <= acc.wr_data;
        end
        `CDP_RDMA_D_SRC_DMA_CFG: begin
          cfg.ram_type <= acc.wr_data[0];
        end
        `CDP_RDMA_D_DATA_FORMAT: begin
          cfg.input_data <= acc.wr_data[`CDP_RDMA_FMT_W-1:0];
        end
        default: ;  // op_enable lives in ctrl
      endcase
    end
  end

  // readback, zero extended
  always_comb begin
    rd_data = '0;
    if (acc.rd_en) begin
      case (acc.offset)
        `CDP_RDMA_D_CUBE_WIDTH:      rd_data[`CDP_RDMA_CUBE_W-1:0] = cfg.width;
        `CDP_RDMA_D_CUBE_HEIGHT:     rd_data[`CDP_RDMA_CUBE_W-1:0] = cfg.height;
        `CDP_RDMA_D_CUBE_CHANNEL:    rd_data[`CDP_RDMA_CUBE_W-1:0] = cfg.channel;
        `CDP_RDMA_D_SRC_BASE_LOW:    rd_data = cfg.base_low;
        `CDP_RDMA_D_SRC_BASE_HIGH:   rd_data = cfg.base_high;
        `CDP_RDMA_D_SRC_LINE_STRIDE: rd_data = cfg.line_stride;
        `CDP_RDMA_D_SRC_SURF_STRIDE: rd_data = cfg.surf_stride;
        `CDP_RDMA_D_SRC_DMA_CFG:     rd_data[0] = cfg.ram_type;
        `CDP_RDMA_D_DATA_FORMAT:     rd_data[`CDP_RDMA_FMT_W-1:0] = cfg.input_data;
        default: ;  // holes read zero
      endcase
    end
  end

endmodule

//--- design/cdp_rdma_reg.sv
`timescale 1ns/10ps
`include "cdp_rdma_reg_macros.svh"

module cdp_rdma_reg
  import cdp_rdma_reg_pkg::*;
(
  input  logic      nvdla_core_clk,
  input  logic      nvdla_core_rstn,
  input  csb_req_t  csb_req,
  input  logic      csb_req_pvld,
  output logic      csb_req_prdy,
  output csb_resp_t csb_resp,
  output logic      csb_resp_valid,
  input  logic      dp2reg_done,
  output rdma_cfg_t reg2dp_cfg,
  output logic      reg2dp_op_en,
  output logic      slcg_op_en
);

  reg_acc_t                    reg_acc;
  logic [`CDP_RDMA_DATA_W-1:0] rd_data;
  reg_acc_t                    grp0_acc;
  reg_acc_t                    grp1_acc;
  logic [`CDP_RDMA_DATA_W-1:0] grp0_rd_data;
  logic [`CDP_RDMA_DATA_W-1:0] grp1_rd_data;
  rdma_cfg_t                   grp0_cfg;
  rdma_cfg_t                   grp1_cfg;

  // csb side
  cdp_rdma_csb_port u_csb_port (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .csb_req         (csb_req),
    .csb_req_pvld    (csb_req_pvld),
    .csb_req_prdy    (csb_req_prdy),
    .rd_data         (rd_data),
    .reg_acc         (reg_acc),
    .csb_resp        (csb_resp),
    .csb_resp_valid  (csb_resp_valid)
  );

  // pointers, op_en, muxing
  cdp_rdma_reg_ctrl u_reg_ctrl (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .reg_acc         (reg_acc),
    .rd_data         (rd_data),
    .grp0_acc        (grp0_acc),
    .grp1_acc        (grp1_acc),
    .grp0_rd_data    (grp0_rd_data),
    .grp1_rd_data    (grp1_rd_data),
    .grp0_cfg        (grp0_cfg),
    .grp1_cfg        (grp1_cfg),
    .dp2reg_done     (dp2reg_done),
    .reg2dp_cfg      (reg2dp_cfg),
    .reg2dp_op_en    (reg2dp_op_en),
    .slcg_op_en      (slcg_op_en)
  );

  // ping-pong pair
  cdp_rdma_cfg_group u_cfg_d0 (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .acc             (grp0_acc),
    .rd_data         (grp0_rd_data),
    .cfg             (grp0_cfg)
  );

  cdp_rdma_cfg_group u_cfg_d1 (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .acc             (grp1_acc),
    .rd_data         (grp1_rd_data),
    .cfg             (grp1_cfg)
  );

endmodule

//--- tb/cdp_rdma_reg_tb.sv
`timescale 1ns/10ps
`include "cdp_rdma_reg_macros.svh"

module cdp_rdma_reg_tb
  import cdp_rdma_reg_pkg::*;
();

  localparam int watchdog_cycles = 2000;  // ~180 directed cycles + 60 random ops of up to 3 cycles

  logic        nvdla_core_clk;
  logic        nvdla_core_rstn;
  csb_req_t    csb_req;
  logic        csb_req_pvld;
  logic        csb_req_prdy;
  csb_resp_t   csb_resp;
  logic        csb_resp_valid;
  logic        dp2reg_done;
  rdma_cfg_t   reg2dp_cfg;
  logic        reg2dp_op_en;
  logic        slcg_op_en;

  integer      seed = 33573;
  int          errors = 0;
  int          resp_seen = 0;

  logic [11:0] dual_offs [9] = '{`CDP_RDMA_D_CUBE_WIDTH, `CDP_RDMA_D_CUBE_HEIGHT,
                                 `CDP_RDMA_D_CUBE_CHANNEL, `CDP_RDMA_D_SRC_BASE_LOW,
                                 `CDP_RDMA_D_SRC_BASE_HIGH, `CDP_RDMA_D_SRC_LINE_STRIDE,
                                 `CDP_RDMA_D_SRC_SURF_STRIDE, `CDP_RDMA_D_SRC_DMA_CFG,
                                 `CDP_RDMA_D_DATA_FORMAT};

  // shadow model state
  logic        m_req_vld;
  csb_req_t    m_req;
  logic [11:0] m_offs;
  logic        m_resp_valid;
  csb_resp_t   m_resp;
  logic        m_producer;
  logic        m_consumer;
  logic [1:0]  m_op_en;
  logic [2:0]  m_op_dly;
  logic [2:0]  m_slcg_dly;
  logic [31:0] m_reg [2][16];  // group by word index
  rdma_cfg_t   m_cfg;

  cdp_rdma_reg cdp_rdma_reg_i (.*);

  initial begin
    nvdla_core_clk = 1'b0;
    forever #5 nvdla_core_clk = ~nvdla_core_clk;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] field_mask(input logic [11:0] offs);
    case (offs)
      `CDP_RDMA_D_CUBE_WIDTH, `CDP_RDMA_D_CUBE_HEIGHT,
      `CDP_RDMA_D_CUBE_CHANNEL:    return {`CDP_RDMA_CUBE_W{1'b1}};
      `CDP_RDMA_D_SRC_BASE_LOW, `CDP_RDMA_D_SRC_BASE_HIGH,
      `CDP_RDMA_D_SRC_LINE_STRIDE,
      `CDP_RDMA_D_SRC_SURF_STRIDE: return 32'hffff_ffff;
      `CDP_RDMA_D_SRC_DMA_CFG:     return 32'h1;  // ram type only
      `CDP_RDMA_D_DATA_FORMAT:     return {`CDP_RDMA_FMT_W{1'b1}};
      default:                     return 32'h0;  // holes
    endcase
  endfunction

  function automatic logic [1:0] grp_status(input logic g);
    if (!m_op_en[g]) return `CDP_RDMA_ST_IDLE;
    return (m_consumer == g) ? `CDP_RDMA_ST_RUNNING : `CDP_RDMA_ST_PENDING;
  endfunction

  function automatic logic [31:0] model_read(input logic [11:0] offs);
    logic [31:0] d;
    d = '0;
    case (offs)
      `CDP_RDMA_S_STATUS: begin
        d[1:0]   = grp_status(1'b0);
        d[17:16] = grp_status(1'b1);
      end
      `CDP_RDMA_S_POINTER: begin
        d[0]  = m_producer;
        d[16] = m_consumer;
      end
      `CDP_RDMA_D_OP_ENABLE: d[0] = m_op_en[m_producer];
      default: d = m_reg[m_producer][offs[5:2]];  // already masked on write
    endcase
    return d;
  endfunction

  assign m_offs = {m_req.addr[9:0], 2'b00};  // word addr to byte offset

  always @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      m_req_vld    <= 1'b0;
      m_resp_valid <= 1'b0;
      m_producer   <= 1'b0;
      m_consumer   <= 1'b0;
      m_op_en      <= '0;
      m_op_dly     <= '0;
      m_slcg_dly   <= '0;
      m_reg        <= '{default: '0};
    end else begin
      m_req_vld <= csb_req_pvld;
      if (csb_req_pvld) begin
        m_req <= csb_req;
      end
      // response one edge after the access cycle
      m_resp_valid <= m_req_vld && (!m_req.write || m_req.nposted);
      if (m_req_vld && !m_req.write) begin
        m_resp <= '{is_write: 1'b0, error: 1'b0, data: model_read(m_offs)};
      end else if (m_req_vld && m_req.nposted) begin
        m_resp <= '{is_write: 1'b1, error: 1'b0, data: '0};
      end
      // done first so a same-edge arm wins
      if (dp2reg_done) begin
        m_consumer          <= ~m_consumer;
        m_op_en[m_consumer] <= 1'b0;
      end
      if (m_req_vld && m_req.write) begin
        case (m_offs)
          `CDP_RDMA_S_POINTER: m_producer <= m_req.wdat[0];
          `CDP_RDMA_D_OP_ENABLE: begin
            if (!m_op_en[m_producer]) m_op_en[m_producer] <= m_req.wdat[0];
          end
          default: begin
            if (m_offs > `CDP_RDMA_D_OP_ENABLE && !m_op_en[m_producer]) begin
              m_reg[m_producer][m_offs[5:2]] <= m_req.wdat & field_mask(m_offs);
            end
          end
        endcase
      end
      m_op_dly   <= dp2reg_done ? '0 : {m_op_dly[1:0], m_op_en[m_consumer]};
      m_slcg_dly <= {m_slcg_dly[1:0], m_op_en[m_consumer]};
    end
  end

  // consumer's group as the data path should see it
  always_comb begin
    m_cfg.width       = m_reg[m_consumer][`CDP_RDMA_D_CUBE_WIDTH >> 2][12:0];
    m_cfg.height      = m_reg[m_consumer][`CDP_RDMA_D_CUBE_HEIGHT >> 2][12:0];
    m_cfg.channel     = m_reg[m_consumer][`CDP_RDMA_D_CUBE_CHANNEL >> 2][12:0];
    m_cfg.input_data  = m_reg[m_consumer][`CDP_RDMA_D_DATA_FORMAT >> 2][1:0];
    m_cfg.base_low    = m_reg[m_consumer][`CDP_RDMA_D_SRC_BASE_LOW >> 2];
    m_cfg.base_high   = m_reg[m_consumer][`CDP_RDMA_D_SRC_BASE_HIGH >> 2];
    m_cfg.line_stride = m_reg[m_consumer][`CDP_RDMA_D_SRC_LINE_STRIDE >> 2];
    m_cfg.surf_stride = m_reg[m_consumer][`CDP_RDMA_D_SRC_SURF_STRIDE >> 2];
    m_cfg.ram_type    = m_reg[m_consumer][`CDP_RDMA_D_SRC_DMA_CFG >> 2][0];
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////
  task automatic report_mismatch(input string name, input logic [255:0] exp,
                                 input logic [255:0] act);
    errors++;
    $display("Fail at %0t: %s expected %0h actual %0h", $time, name, exp, act);
  endtask

  a_prdy: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    csb_req_prdy == 1'b1)
    else report_mismatch("csb_req_prdy", 1'b1, $sampled(csb_req_prdy));
  a_resp_valid: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    csb_resp_valid == m_resp_valid)
    else report_mismatch("csb_resp_valid", $sampled(m_resp_valid), $sampled(csb_resp_valid));
  a_resp: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    csb_resp_valid |-> csb_resp == m_resp)
    else report_mismatch("csb_resp", $sampled(m_resp), $sampled(csb_resp));
  a_op_en: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    reg2dp_op_en == m_op_dly[2])
    else report_mismatch("reg2dp_op_en", $sampled(m_op_dly[2]), $sampled(reg2dp_op_en));
  a_slcg: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    slcg_op_en == m_slcg_dly[2])
    else report_mismatch("slcg_op_en", $sampled(m_slcg_dly[2]), $sampled(slcg_op_en));
  a_cfg: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    reg2dp_cfg == m_cfg)
    else report_mismatch("reg2dp_cfg", $sampled(m_cfg), $sampled(reg2dp_cfg));

  //////////////////////////////////////////////////////////////////////
  // csb driver on the falling edge
  //////////////////////////////////////////////////////////////////////
  task automatic send_req(input logic [11:0] offs, input logic [31:0] data,
                          input logic wr, input logic np);
    @(negedge nvdla_core_clk);
    csb_req.addr    = 22'(offs >> 2);
    csb_req.wdat    = data;
    csb_req.write   = wr;
    csb_req.nposted = np;
    csb_req.srcpriv = 1'b0;
    csb_req.wrbe    = 4'hf;
    csb_req.level   = 2'd0;
    csb_req_pvld    = 1'b1;
    @(negedge nvdla_core_clk);
    csb_req_pvld = 1'b0;
    if (!wr || np) begin
      while (!csb_resp_valid) @(negedge nvdla_core_clk);  // watchdog bounds this
      resp_seen++;
    end
  endtask

  task automatic write_reg(input logic [11:0] offs, input logic [31:0] data, input logic np);
    send_req(offs, data, 1'b1, np);
  endtask

  task automatic read_reg(input logic [11:0] offs);
    send_req(offs, 32'h0, 1'b0, 1'b0);
  endtask

  task automatic pulse_done();
    @(negedge nvdla_core_clk);
    dp2reg_done = 1'b1;
    @(negedge nvdla_core_clk);
    dp2reg_done = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge nvdla_core_clk);
  endtask

  // random fill of the producer's group and full readback
  task automatic program_group();
    foreach (dual_offs[i]) write_reg(dual_offs[i], $random(seed), i[0]);
    foreach (dual_offs[i]) read_reg(dual_offs[i]);
  endtask

  initial begin
    repeat (watchdog_cycles) @(posedge nvdla_core_clk);
    $display("watchdog expired, the test sequence did not finish in time");
    $display("Errors found");
    $finish;
  end

  initial begin
    int op;
    int k;
    csb_req         = '0;
    csb_req_pvld    = 1'b0;
    dp2reg_done     = 1'b0;
    nvdla_core_rstn = 1'b0;
    idle_cycles(10);
    nvdla_core_rstn = 1'b1;
    read_reg(`CDP_RDMA_S_POINTER);  // pointers out of reset
    program_group();                // group 0
    write_reg(`CDP_RDMA_S_POINTER, 32'h1, 1'b1);
    program_group();                // group 1
    // arm group 0 while it is the consumer
    write_reg(`CDP_RDMA_S_POINTER, 32'h0, 1'b0);
    write_reg(`CDP_RDMA_D_OP_ENABLE, 32'h1, 1'b1);
    read_reg(`CDP_RDMA_S_STATUS);
    read_reg(`CDP_RDMA_D_OP_ENABLE);
    idle_cycles(5);
    // locked group keeps its fields
    write_reg(`CDP_RDMA_D_CUBE_WIDTH, $random(seed), 1'b1);
    write_reg(`CDP_RDMA_D_SRC_BASE_LOW, $random(seed), 1'b0);
    read_reg(`CDP_RDMA_D_CUBE_WIDTH);
    read_reg(`CDP_RDMA_D_SRC_BASE_LOW);
    // group 1 armed behind it as pending
    write_reg(`CDP_RDMA_S_POINTER, 32'h1, 1'b1);
    write_reg(`CDP_RDMA_D_OP_ENABLE, 32'h1, 1'b0);
    read_reg(`CDP_RDMA_S_STATUS);
    pulse_done();                   // consumer hops to group 1
    idle_cycles(5);
    read_reg(`CDP_RDMA_S_STATUS);
    read_reg(`CDP_RDMA_S_POINTER);
    pulse_done();
    idle_cycles(5);
    read_reg(`CDP_RDMA_S_STATUS);   // both idle again
    // mixed random traffic
    repeat (60) begin
      op = $unsigned($random(seed)) % 5;
      k  = $unsigned($random(seed)) % 11;
      if (k < 9) k = dual_offs[k];
      else       k = (k == 9) ? `CDP_RDMA_S_POINTER : `CDP_RDMA_D_OP_ENABLE;
      case (op)
        0, 1:    read_reg(12'(k));
        2:       write_reg(12'(k), $random(seed), 1'b0);
        3:       write_reg(12'(k), $random(seed), 1'b1);
        default: pulse_done();
      endcase
    end
    idle_cycles(5);
    $display("errors: %0d, responses checked: %0d", errors, resp_seen);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- cdp_rdma_reg.f
+incdir+design
design/cdp_rdma_reg_pkg.sv
design/cdp_rdma_csb_port.sv
design/cdp_rdma_reg_ctrl.sv
design/cdp_rdma_cfg_group.sv
design/cdp_rdma_reg.sv
tb/cdp_rdma_reg_tb.sv

//--- Bender.yml
package:
  name: cdp_rdma_reg

sources:
  - include_dirs:
      - design
    files:
      - design/cdp_rdma_reg_pkg.sv
      - design/cdp_rdma_csb_port.sv
      - design/cdp_rdma_reg_ctrl.sv
      - design/cdp_rdma_cfg_group.sv
      - design/cdp_rdma_reg.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/cdp_rdma_reg_tb.sv
